// ==== Bender.yml ====
package:
  name: lsu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lsu_pkg.sv
      - rtl/lsu_tlb.sv
      - rtl/lsu_l1d.sv
      - rtl/lsu_replay_q.sv
      - rtl/lsu_refill.sv
      - rtl/lsu_pipe.sv
      - rtl/lsu_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/lsu_checker.sv
      - dv/lsu_tb.sv

// ==== dv/lsu_checker.sv ====
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_checker import lsu_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  issue_t               i_issue,
  input  logic                 i_issue_ready,
  input  done_t                i_done,
  input  status_e              i_exp_status,
  input  logic [`LSU_XLEN-1:0] i_exp_data,
  input  logic [3:0]           i_exp_lat,
  input  logic                 i_end,
  output int                   o_pass_cnt,
  output int                   o_fail_cnt,
  output int                   o_outstanding
);

  localparam int TAGS = 1 << `LSU_TAG_W;

  logic [TAGS-1:0]      pending;
  status_e              exp_status [TAGS];
  logic [`LSU_XLEN-1:0] exp_data [TAGS];
  logic [3:0]           exp_lat [TAGS];
  int                   accept_cycle [TAGS];
  int                   cycle_cnt;

  // Replays reorder completions, so match by tag
  task automatic check_done();
    int rd;
    int lat;
    int errs;
    rd   = i_done.rd;
    lat  = cycle_cnt - accept_cycle[rd] - 1;
    errs = 0;
    if (!pending[rd]) begin
      $display("completion for tag %0d with no load outstanding", rd);
      o_fail_cnt++;
    end else begin
      if (i_done.status !== exp_status[rd]) begin
        $display("** Error: o_done.status rd=%0d expected %h got %h",
                 rd, exp_status[rd], i_done.status);
        errs++;
      end
      if (i_done.data !== exp_data[rd]) begin
        $display("** Error: o_done.data rd=%0d expected %h got %h",
                 rd, exp_data[rd], i_done.data);
        errs++;
      end
      if (exp_lat[rd] != 0 && lat != int'(exp_lat[rd])) begin
        $display("load rd=%0d finished %0d cycles after issue instead of %0d",
                 rd, lat, exp_lat[rd]);
        errs++;
      end
      if (errs == 0) begin
        $display("load rd=%0d passed: status %h data %h after %0d cycles",
                 rd, i_done.status, i_done.data, lat);
        o_pass_cnt++;
      end else begin
        o_fail_cnt++;
      end
      pending[rd] = 1'b0;
    end
  endtask

  initial begin
    o_pass_cnt    = 0;
    o_fail_cnt    = 0;
    o_outstanding = 0;
    cycle_cnt     = 0;
    pending       = '0;
  end

  // Sampled on the falling edge away from DUT updates
  always @(negedge i_clk) begin
    cycle_cnt++;
    if (!i_reset_n) begin
      pending = '0;
    end else begin
      if (i_done.valid) begin
        check_done();
      end
      if (i_issue.valid && i_issue_ready) begin
        if (pending[i_issue.rd]) begin
          $display("tag %0d issued again while its load is outstanding", i_issue.rd);
          o_fail_cnt++;
        end
        pending[i_issue.rd]      = 1'b1;
        exp_status[i_issue.rd]   = i_exp_status;
        exp_data[i_issue.rd]     = i_exp_data;
        exp_lat[i_issue.rd]      = i_exp_lat;
        accept_cycle[i_issue.rd] = cycle_cnt;
      end
      if (i_end) begin
        for (int t = 0; t < TAGS; t++) begin
          if (pending[t]) begin
            $display("load rd=%0d never completed", t);
            o_fail_cnt++;
            pending[t] = 1'b0;
          end
        end
      end
    end
    o_outstanding = $countones(pending);
  end

endmodule

// ==== dv/lsu_tb.sv ====
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_tb import lsu_pkg::*; ();

  localparam int MAX_VEC = 32;
  localparam int COLS    = 7;

  logic    clk = 1'b0;
  logic    reset_n;
  issue_t  issue;
  logic    issue_ready;
  tlb_wr_t tlb_wr;
  done_t   done;
  logic    mem_arready;
  logic    mem_arvalid;
  axi_ar_t mem_ar;
  logic    mem_rvalid;
  axi_r_t  mem_r;
  logic    mem_rready;

  status_e              exp_status;
  logic [`LSU_XLEN-1:0] exp_data;
  logic [3:0]           exp_lat;
  logic                 end_of_run;
  int                   pass_cnt;
  int                   fail_cnt;
  int                   outstanding;

  logic [63:0] vec_mem [MAX_VEC*COLS];
  int          num_vec;
  int          timeout_limit = 200;
  int          cycle_cnt = 0;
  int          stall_cycles = 0;
  int          tb_errs = 0;

  always #5 clk = ~clk;

  lsu_top u_dut (
    .i_clk(clk), .i_reset_n(reset_n),
    .i_issue(issue), .o_issue_ready(issue_ready),
    .i_tlb_wr(tlb_wr), .o_done(done),
    .i_mem_arready(mem_arready), .o_mem_arvalid(mem_arvalid), .o_mem_ar(mem_ar),
    .i_mem_rvalid(mem_rvalid), .i_mem_r(mem_r), .o_mem_rready(mem_rready)
  );

  lsu_checker u_check (
    .i_clk(clk), .i_reset_n(reset_n),
    .i_issue(issue), .i_issue_ready(issue_ready), .i_done(done),
    .i_exp_status(exp_status), .i_exp_data(exp_data), .i_exp_lat(exp_lat),
    .i_end(end_of_run),
    .o_pass_cnt(pass_cnt), .o_fail_cnt(fail_cnt), .o_outstanding(outstanding)
  );

  // Inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    if (act_val !== exp_val) begin
      $display("** Error: %s expected %h got %h", name, exp_val, act_val);
      tb_errs++;
    end
  endtask

  task automatic wait_idle(input int max_cycles);
    int n;
    n = 0;
    while (outstanding != 0 && n < max_cycles) begin
      tick();
      n++;
    end
  endtask

  task automatic write_tlb(input logic [63:0] slot, input logic [63:0] vpn,
                           input logic [63:0] ppn);
    tlb_wr.valid = 1'b1;
    tlb_wr.slot  = slot[$clog2(`LSU_TLB_ENTRIES)-1:0];
    tlb_wr.vpn   = vpn[`LSU_VADDR_W-`LSU_PAGE_W-1:0];
    tlb_wr.ppn   = ppn[`LSU_PADDR_W-`LSU_PAGE_W-1:0];
    tick();
    tlb_wr = '0;
  endtask

  task automatic issue_load(input logic [63:0] rd, input logic [63:0] base,
                            input logic [63:0] offset, input logic [63:0] status,
                            input logic [63:0] data, input logic [63:0] lat);
    logic taken;
    issue.valid  = 1'b1;
    issue.rd     = rd[`LSU_TAG_W-1:0];
    issue.base   = base[`LSU_VADDR_W-1:0];
    issue.offset = offset[11:0];
    issue.replay = 1'b0;
    exp_status   = status_e'(status[1:0]);
    exp_data     = data[`LSU_XLEN-1:0];
    exp_lat      = lat[3:0];
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = issue_ready;
      if (!taken) begin
        stall_cycles++;
      end
      tick();
    end
    issue = '0;
  endtask

  initial begin
    int k;
    logic [63:0] kind;
    reset_n    = 1'b0;
    issue      = '0;
    tlb_wr     = '0;
    exp_status = STATUS_OK;
    exp_data   = '0;
    exp_lat    = '0;
    end_of_run = 1'b0;
    for (int i = 0; i < MAX_VEC * COLS; i++) begin
      vec_mem[i] = '0;
    end
    $readmemh("dv/lsu_vectors.txt", vec_mem);
    num_vec = 0;
    while (num_vec < MAX_VEC && vec_mem[num_vec*COLS] != 0) begin
      num_vec++;
    end
    timeout_limit = 40 * num_vec + 200;
    if (num_vec == 0) begin
      $display("no vectors were read from dv/lsu_vectors.txt");
      tb_errs++;
    end

    repeat (2) @(posedge clk);
    #1 reset_n = 1'b1;
    check_value("o_done.valid", 64'd0, done.valid);
    check_value("o_mem_arvalid", 64'd0, mem_arvalid);
    check_value("o_mem_rready", 64'd0, mem_rready);
    check_value("o_issue_ready", 64'd1, issue_ready);

    for (int v = 0; v < num_vec; v++) begin
      k    = v * COLS;
      kind = vec_mem[k];
      // TLB writes and kind 3 loads start on an idle pipe
      if (kind != 2) begin
        wait_idle(100);
      end
      if (kind == 1) begin
        write_tlb(vec_mem[k+1], vec_mem[k+2], vec_mem[k+3]);
      end else begin
        issue_load(vec_mem[k+1], vec_mem[k+2], vec_mem[k+3], vec_mem[k+4],
                   vec_mem[k+5], vec_mem[k+6]);
      end
    end

    wait_idle(100);
    end_of_run = 1'b1;
    tick();
    end_of_run = 1'b0;
    if (stall_cycles == 0) begin
      $display("issue port never stalled during the load burst");
      tb_errs++;
    end else begin
      $display("issue port stalled for %0d cycles", stall_cycles);
    end
    $display("loads: %0d passed, %0d failed, other errors: %0d", pass_cnt, fail_cnt, tb_errs);
    if (fail_cnt == 0 && tb_errs == 0 && pass_cnt > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // AXI4-Lite read slave returning {P, ~P} for the doubleword at P
  initial begin
    int unsigned seed_ret;
    int unsigned delay;
    logic [`LSU_PADDR_W-1:0] addr;
    axi_ar_t ar_held;
    mem_arready = 1'b0;
    mem_rvalid  = 1'b0;
    mem_r       = '0;
    seed_ret    = $urandom(32'h59e52394);
    forever begin
      tick();
      if (reset_n && mem_arvalid) begin
        ar_held = mem_ar;
        delay = $urandom_range(3, 0);
        repeat (delay) begin
          tick();
          check_value("o_mem_arvalid", 64'd1, mem_arvalid);
          check_value("o_mem_ar", ar_held, mem_ar);
        end
        mem_arready = 1'b1;
        addr        = mem_ar.araddr;
        tick();
        mem_arready = 1'b0;
        delay = $urandom_range(3, 0);
        repeat (delay) tick();
        check_value("o_mem_rready", 64'd1, mem_rready);
        mem_rvalid  = 1'b1;
        mem_r.rdata = {addr, ~addr};
        mem_r.rresp = 2'b00;
        tick();
        mem_rvalid  = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_limit) begin
      $display("timeout: run stopped after %0d cycles with %0d loads outstanding",
               cycle_cnt, outstanding);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

endmodule

// ==== dv/lsu_vectors.txt ====
// kind: 1 TLB write (slot vpn ppn), 2 load, 3 load once earlier loads have finished
// load columns: rd base offset status data latency (latency 0 is not checked)
1 0 00010 00080 0 0 0
1 1 00011 00200 0 0 0
1 2 00020 00333 0 0 0
3 01 00050000 000 1 0000000000000000 2
3 02 00010100 010 0 00080110fff7feef 0
3 03 00010118 ff8 0 00080110fff7feef 3
3 04 00010115 000 0 00080110fff7feef 3
3 05 00011004 fe0 0 00080fe0fff7f01f 0
3 06 00011000 7f8 0 002007f8ffdff807 0
3 07 00020000 000 0 00333000ffcccfff 0
2 08 00020008 000 0 00333008ffcccff7 0
2 09 00020000 004 0 00333000ffcccfff 0
2 0a 00020020 008 0 00333028ffcccfd7 0
2 0b 00020010 008 0 00333018ffcccfe7 0
2 0c 00020008 000 0 00333008ffcccff7 0
1 2 00020 00444 0 0 0
3 0d 00020000 000 0 00444000ffbbbfff 0
3 0e 00020000 000 0 00444000ffbbbfff 3

// ==== rtl/lsu_l1d.sv ====
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_l1d import lsu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  l1d_req_t  i_l1d_req,
  input  refill_t   i_refill,
  output l1d_resp_t o_l1d_resp
);

  localparam int INDEX_W = $clog2(`LSU_L1D_LINES);
  localparam int LTAG_W  = `LSU_PADDR_W - INDEX_W - 3;

  logic [`LSU_L1D_LINES-1:0] r_valid;
  logic [LTAG_W-1:0]         r_tag  [`LSU_L1D_LINES];
  logic [`LSU_XLEN-1:0]      r_data [`LSU_L1D_LINES];

  logic [INDEX_W-1:0] w_req_idx;
  logic [INDEX_W-1:0] w_fill_idx;
  logic [LTAG_W-1:0]  w_req_tag;
  logic [LTAG_W-1:0]  w_fill_tag;
  logic               w_fill_clash;
  logic               w_hit;

  logic                 r_hit;
  logic [`LSU_XLEN-1:0] r_rdata;

  assign w_req_idx  = i_l1d_req.paddr[INDEX_W+2:3];
  assign w_req_tag  = i_l1d_req.paddr[`LSU_PADDR_W-1:INDEX_W+3];
  assign w_fill_idx = i_refill.paddr[INDEX_W+2:3];
  assign w_fill_tag = i_refill.paddr[`LSU_PADDR_W-1:INDEX_W+3];

  // Line being rewritten this cycle reads as a miss
  assign w_fill_clash = i_refill.valid && (w_fill_idx == w_req_idx);
  assign w_hit = i_l1d_req.valid && r_valid[w_req_idx] &&
                 (r_tag[w_req_idx] == w_req_tag) && !w_fill_clash;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      r_hit   <= 1'b0;
    end else begin
      r_hit <= w_hit;
      if (i_refill.valid) begin
        r_valid[w_fill_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    r_rdata <= r_data[w_req_idx];
    if (i_refill.valid) begin
      r_tag[w_fill_idx]  <= w_fill_tag;
      r_data[w_fill_idx] <= i_refill.data;
    end
  end

  assign o_l1d_resp.hit  = r_hit;
  assign o_l1d_resp.data = r_rdata;

endmodule

// ==== rtl/lsu_macros.svh ====
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Address and data widths
`define LSU_VADDR_W 32
`define LSU_PADDR_W 32
`define LSU_PAGE_W 12
`define LSU_XLEN 64

// Destination tag of a load
`define LSU_TAG_W 5

// Structure sizes
`define LSU_TLB_ENTRIES 4
`define LSU_L1D_LINES 8
`define LSU_RQ_SIZE 4

`endif

// ==== rtl/lsu_pipe.sv ====
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_pipe import lsu_pkg::*; (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  input  issue_t                            i_issue,
  output logic                              o_issue_ready,
  input  issue_t                            i_replay,
  input  logic [$clog2(`LSU_RQ_SIZE+1)-1:0] i_rq_free,
  output logic                              o_replay_take,
  output tlb_req_t                          o_tlb_req,
  input  tlb_resp_t                         i_tlb_resp,
  output l1d_req_t                          o_l1d_req,
  input  l1d_resp_t                         i_l1d_resp,
  output miss_t                             o_miss,
  output done_t                             o_done
);

  localparam int CNT_W = $clog2(`LSU_RQ_SIZE + 1);

  issue_t                  r_ex0, r_ex1, r_ex2;
  issue_t                  w_ex0_next, w_ex2_next;
  logic                    r_ex2_tlb_miss;
  logic [`LSU_PADDR_W-1:0] r_ex2_paddr;
  done_t                   r_done, w_done_next;

  logic [`LSU_VADDR_W-1:0] w_ex1_sum;
  logic [`LSU_VADDR_W-1:0] w_ex1_vaddr;
  logic [`LSU_PADDR_W-1:0] w_ex1_paddr;
  logic                    w_ex1_tlb_miss, w_ex1_early, w_ex2_finish;
  logic [CNT_W-1:0]        w_inflight;

  // Every load still ahead of EX3 may claim a queue slot
  assign w_inflight = CNT_W'(r_ex0.valid) + CNT_W'(r_ex1.valid) +
                      CNT_W'(r_ex2.valid & !r_ex2_tlb_miss);
  assign o_issue_ready = !i_replay.valid && (i_rq_free > w_inflight);
  assign o_replay_take = i_replay.valid;

  always_comb begin
    w_ex0_next = '0;
    if (i_replay.valid) begin
      w_ex0_next = i_replay;
    end else if (i_issue.valid && o_issue_ready) begin
      w_ex0_next        = i_issue;
      w_ex0_next.replay = 1'b0;
    end
  end

  // EX1 address generation and translation
  assign w_ex1_sum   = r_ex1.base + {{(`LSU_VADDR_W-12){r_ex1.offset[11]}}, r_ex1.offset};
  assign w_ex1_vaddr = {w_ex1_sum[`LSU_VADDR_W-1:3], 3'b000};

  assign o_tlb_req.valid = r_ex1.valid & !r_ex1.replay;
  assign o_tlb_req.vaddr = w_ex1_vaddr;
  assign w_ex1_tlb_miss  = o_tlb_req.valid & !i_tlb_resp.hit;

  // Replays already hold the physical address in base
  assign w_ex1_paddr = r_ex1.replay ? {r_ex1.base[`LSU_PADDR_W-1:3], 3'b000}
                                    : i_tlb_resp.paddr;
  assign o_l1d_req.valid = r_ex1.valid & !w_ex1_tlb_miss;
  assign o_l1d_req.paddr = w_ex1_paddr;

  // EX2 cache result
  assign w_ex2_finish = r_ex2.valid & (r_ex2_tlb_miss | i_l1d_resp.hit);
  // Early finish only when EX2 is not completing this cycle
  assign w_ex1_early  = w_ex1_tlb_miss & !w_ex2_finish;

  assign o_miss.valid = r_ex2.valid & !r_ex2_tlb_miss & !i_l1d_resp.hit;
  assign o_miss.paddr = r_ex2_paddr;
  assign o_miss.rd    = r_ex2.rd;

  always_comb begin
    w_ex2_next       = r_ex1;
    w_ex2_next.valid = r_ex1.valid & !w_ex1_early;
  end

  always_comb begin
    w_done_next = '0;
    if (w_ex2_finish) begin
      w_done_next.valid  = 1'b1;
      w_done_next.rd     = r_ex2.rd;
      w_done_next.status = r_ex2_tlb_miss ? STATUS_TLB_MISS : STATUS_OK;
      w_done_next.data   = r_ex2_tlb_miss ? '0 : i_l1d_resp.data;
    end else if (w_ex1_early) begin
      w_done_next.valid  = 1'b1;
      w_done_next.rd     = r_ex1.rd;
      w_done_next.status = STATUS_TLB_MISS;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0          <= '0;
      r_ex1          <= '0;
      r_ex2          <= '0;
      r_ex2_tlb_miss <= 1'b0;
      r_done         <= '0;
    end else begin
      r_ex0          <= w_ex0_next;
      r_ex1          <= r_ex0;
      r_ex2          <= w_ex2_next;
      r_ex2_tlb_miss <= w_ex1_tlb_miss;
      r_done         <= w_done_next;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex2_paddr <= w_ex1_paddr;
  end

  assign o_done = r_done;

endmodule

// ==== rtl/lsu_pkg.sv ====
`include "lsu_macros.svh"

package lsu_pkg;

  typedef enum logic [1:0] {
    STATUS_OK       = 2'd0,
    STATUS_TLB_MISS = 2'd1
  } status_e;

  typedef struct packed {
    logic                    valid;
    logic [`LSU_TAG_W-1:0]   rd;
    logic [`LSU_VADDR_W-1:0] base;
    logic signed [11:0]      offset;
    logic                    replay;
  } issue_t;

  typedef struct packed {
    logic                                     valid;
    logic [$clog2(`LSU_TLB_ENTRIES)-1:0]      slot;
    logic [`LSU_VADDR_W-`LSU_PAGE_W-1:0]      vpn;
    logic [`LSU_PADDR_W-`LSU_PAGE_W-1:0]      ppn;
  } tlb_wr_t;

  typedef struct packed {
    logic                    valid;
    logic [`LSU_VADDR_W-1:0] vaddr;
  } tlb_req_t;

  typedef struct packed {
    logic                    hit;
    logic [`LSU_PADDR_W-1:0] paddr;
  } tlb_resp_t;

  typedef struct packed {
    logic                    valid;
    logic [`LSU_PADDR_W-1:0] paddr;
  } l1d_req_t;

  typedef struct packed {
    logic                 hit;
    logic [`LSU_XLEN-1:0] data;
  } l1d_resp_t;

  typedef struct packed {
    logic                    valid;
    logic [`LSU_PADDR_W-1:0] paddr;
    logic [`LSU_XLEN-1:0]    data;
  } refill_t;

  typedef struct packed {
    logic                    valid;
    logic [`LSU_PADDR_W-1:0] paddr;
    logic [`LSU_TAG_W-1:0]   rd;
  } miss_t;

  typedef struct packed {
    logic                  valid;
    logic [`LSU_TAG_W-1:0] rd;
    status_e               status;
    logic [`LSU_XLEN-1:0]  data;
  } done_t;

  typedef struct packed {
    logic [`LSU_PADDR_W-1:0] araddr;
    logic [2:0]              arprot;
  } axi_ar_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] rdata;
    logic [1:0]           rresp;
  } axi_r_t;

endpackage

// ==== rtl/lsu_refill.sv ====
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_refill import lsu_pkg::*; (
  input  logic     i_clk,
  input  logic     i_reset_n,
  input  l1d_req_t i_refill_req,
  output logic     o_refill_grant,
  output logic     o_mem_arvalid,
  output axi_ar_t  o_mem_ar,
  input  logic     i_mem_arready,
  input  logic     i_mem_rvalid,
  input  axi_r_t   i_mem_r,
  output logic     o_mem_rready,
  output refill_t  o_refill
);

  typedef enum logic [1:0] {RF_IDLE, RF_ADDR, RF_DATA} rf_state_e;

  rf_state_e               r_state;
  logic [`LSU_PADDR_W-1:0] r_addr;

  assign o_refill_grant = (r_state == RF_IDLE) && i_refill_req.valid;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= RF_IDLE;
    end else begin
      case (r_state)
        RF_IDLE: if (o_refill_grant) r_state <= RF_ADDR;
        RF_ADDR: if (i_mem_arready) r_state <= RF_DATA;
        RF_DATA: if (i_mem_rvalid) r_state <= RF_IDLE;
        default: r_state <= RF_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_refill_grant) begin
      r_addr <= {i_refill_req.paddr[`LSU_PADDR_W-1:3], 3'b000};
    end
  end

  // Unprivileged secure data access
  assign o_mem_arvalid   = r_state == RF_ADDR;
  assign o_mem_ar.araddr = r_addr;
  assign o_mem_ar.arprot = 3'b000;
  assign o_mem_rready    = r_state == RF_DATA;

  assign o_refill.valid = o_mem_rready & i_mem_rvalid;
  assign o_refill.paddr = r_addr;
  assign o_refill.data  = i_mem_r.rdata;

endmodule

// ==== rtl/lsu_replay_q.sv ====
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_replay_q import lsu_pkg::*; (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  input  miss_t                               i_miss,
  input  refill_t                             i_refill,
  input  logic                                i_replay_take,
  output issue_t                              o_replay,
  output logic [$clog2(`LSU_RQ_SIZE+1)-1:0]   o_rq_free,
  output l1d_req_t                            o_refill_req,
  input  logic                                i_refill_grant
);

  localparam int N     = `LSU_RQ_SIZE;
  localparam int IDX_W = $clog2(N);

  typedef enum logic [1:0] {RQ_FREE, RQ_NEED, RQ_WAIT, RQ_READY} rq_state_e;

  rq_state_e               r_state [N];
  logic [`LSU_PADDR_W-1:0] r_paddr [N];
  logic [`LSU_TAG_W-1:0]   r_rd [N];
  // Bit j set when entry j was allocated before entry i
  logic [N-1:0]            r_older [N];

  logic [N-1:0] w_busy, w_need, w_fill_hit, w_grant_hit;
  logic [IDX_W-1:0] w_alloc_idx, w_pick_idx, w_req_idx;
  logic w_pick_vld, w_req_vld, w_line_wait, w_miss_fill;
  logic [$clog2(N+1)-1:0] w_free_cnt;

  always_comb begin
    w_free_cnt  = '0;
    w_alloc_idx = '0;
    w_pick_idx  = '0;
    w_req_idx   = '0;
    w_pick_vld  = 1'b0;
    w_req_vld   = 1'b0;
    w_line_wait = 1'b0;
    for (int i = N - 1; i >= 0; i--) begin
      w_busy[i]     = r_state[i] != RQ_FREE;
      w_need[i]     = r_state[i] == RQ_NEED;
      w_fill_hit[i] = i_refill.valid && (r_paddr[i][`LSU_PADDR_W-1:3] ==
                                         i_refill.paddr[`LSU_PADDR_W-1:3]);
      if (!w_busy[i]) begin
        w_free_cnt  = w_free_cnt + 1'b1;
        w_alloc_idx = IDX_W'(i);
      end
      if (r_state[i] == RQ_READY) begin
        w_pick_vld = 1'b1;
        w_pick_idx = IDX_W'(i);
      end
      if ((r_state[i] == RQ_WAIT) && (r_paddr[i][`LSU_PADDR_W-1:3] ==
                                      i_miss.paddr[`LSU_PADDR_W-1:3])) begin
        w_line_wait = 1'b1;
      end
    end
    // Oldest entry still needing a refill
    for (int i = 0; i < N; i++) begin
      if (w_need[i] && !(|(w_need & r_older[i]))) begin
        w_req_vld = 1'b1;
        w_req_idx = IDX_W'(i);
      end
    end
    for (int i = 0; i < N; i++) begin
      w_grant_hit[i] = i_refill_grant && w_need[i] &&
                       (r_paddr[i][`LSU_PADDR_W-1:3] == r_paddr[w_req_idx][`LSU_PADDR_W-1:3]);
    end
  end

  assign w_miss_fill = i_refill.valid && (i_miss.paddr[`LSU_PADDR_W-1:3] ==
                                          i_refill.paddr[`LSU_PADDR_W-1:3]);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < N; i++) begin
        r_state[i] <= RQ_FREE;
      end
    end else begin
      for (int i = 0; i < N; i++) begin
        if ((r_state[i] == RQ_NEED || r_state[i] == RQ_WAIT) && w_fill_hit[i]) begin
          r_state[i] <= RQ_READY;
        end else if (w_grant_hit[i]) begin
          r_state[i] <= RQ_WAIT;
        end else if (i_replay_take && (r_state[i] == RQ_READY) && (w_pick_idx == IDX_W'(i))) begin
          r_state[i] <= RQ_FREE;
        end
      end
      if (i_miss.valid) begin
        r_state[w_alloc_idx] <= w_miss_fill ? RQ_READY : (w_line_wait ? RQ_WAIT : RQ_NEED);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_miss.valid) begin
      r_paddr[w_alloc_idx] <= i_miss.paddr;
      r_rd[w_alloc_idx]    <= i_miss.rd;
      r_older[w_alloc_idx] <= w_busy;
      for (int i = 0; i < N; i++) begin
        if (IDX_W'(i) != w_alloc_idx) begin
          r_older[i][w_alloc_idx] <= 1'b0;
        end
      end
    end
  end

  assign o_rq_free          = w_free_cnt;
  assign o_refill_req.valid = w_req_vld;
  assign o_refill_req.paddr = r_paddr[w_req_idx];

  assign o_replay.valid  = w_pick_vld;
  assign o_replay.rd     = r_rd[w_pick_idx];
  assign o_replay.base   = `LSU_VADDR_W'(r_paddr[w_pick_idx]);
  assign o_replay.offset = '0;
  assign o_replay.replay = 1'b1;

endmodule

// ==== rtl/lsu_tlb.sv ====
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_tlb import lsu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  tlb_wr_t   i_tlb_wr,
  input  tlb_req_t  i_tlb_req,
  output tlb_resp_t o_tlb_resp
);

  localparam int VPN_W = `LSU_VADDR_W - `LSU_PAGE_W;
  localparam int PPN_W = `LSU_PADDR_W - `LSU_PAGE_W;

  logic [`LSU_TLB_ENTRIES-1:0] r_valid;
  logic [VPN_W-1:0]            r_vpn [`LSU_TLB_ENTRIES];
  logic [PPN_W-1:0]            r_ppn [`LSU_TLB_ENTRIES];
  logic [VPN_W-1:0]            w_vpn;
  logic                        w_hit;
  logic [PPN_W-1:0]            w_ppn;

  assign w_vpn = i_tlb_req.vaddr[`LSU_VADDR_W-1:`LSU_PAGE_W];

  // All entries compared at once and the first match wins
  always_comb begin
    w_hit = 1'b0;
    w_ppn = '0;
    for (int i = 0; i < `LSU_TLB_ENTRIES; i++) begin
      if (!w_hit && r_valid[i] && (r_vpn[i] == w_vpn)) begin
        w_hit = 1'b1;
        w_ppn = r_ppn[i];
      end
    end
  end

  assign o_tlb_resp.hit   = i_tlb_req.valid & w_hit;
  assign o_tlb_resp.paddr = {w_ppn, i_tlb_req.vaddr[`LSU_PAGE_W-1:0]};

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (i_tlb_wr.valid) begin
      r_valid[i_tlb_wr.slot] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_tlb_wr.valid) begin
      r_vpn[i_tlb_wr.slot] <= i_tlb_wr.vpn;
      r_ppn[i_tlb_wr.slot] <= i_tlb_wr.ppn;
    end
  end

endmodule

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_top import lsu_pkg::*; (
  input  logic    i_clk,
  input  logic    i_reset_n,
  input  issue_t  i_issue,
  output logic    o_issue_ready,
  input  tlb_wr_t i_tlb_wr,
  output done_t   o_done,
  input  logic    i_mem_arready,
  output logic    o_mem_arvalid,
  output axi_ar_t o_mem_ar,
  input  logic    i_mem_rvalid,
  input  axi_r_t  i_mem_r,
  output logic    o_mem_rready
);

  issue_t    w_replay;
  logic      w_replay_take;
  logic [$clog2(`LSU_RQ_SIZE+1)-1:0] w_rq_free;
  tlb_req_t  w_tlb_req;
  tlb_resp_t w_tlb_resp;
  l1d_req_t  w_l1d_req;
  l1d_resp_t w_l1d_resp;
  miss_t     w_miss;
  refill_t   w_refill;
  l1d_req_t  w_refill_req;
  logic      w_refill_grant;

  lsu_pipe u_pipe (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_issue(i_issue), .o_issue_ready(o_issue_ready),
    .i_replay(w_replay), .i_rq_free(w_rq_free), .o_replay_take(w_replay_take),
    .o_tlb_req(w_tlb_req), .i_tlb_resp(w_tlb_resp),
    .o_l1d_req(w_l1d_req), .i_l1d_resp(w_l1d_resp),
    .o_miss(w_miss), .o_done(o_done)
  );

  lsu_tlb u_tlb (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_tlb_wr(i_tlb_wr),
    .i_tlb_req(w_tlb_req), .o_tlb_resp(w_tlb_resp)
  );

  lsu_l1d u_l1d (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_l1d_req(w_l1d_req),
    .i_refill(w_refill), .o_l1d_resp(w_l1d_resp)
  );

  lsu_replay_q u_replay_q (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_miss(w_miss), .i_refill(w_refill),
    .i_replay_take(w_replay_take), .o_replay(w_replay), .o_rq_free(w_rq_free),
    .o_refill_req(w_refill_req), .i_refill_grant(w_refill_grant)
  );

  lsu_refill u_refill (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_refill_req(w_refill_req), .o_refill_grant(w_refill_grant),
    .o_mem_arvalid(o_mem_arvalid), .o_mem_ar(o_mem_ar), .i_mem_arready(i_mem_arready),
    .i_mem_rvalid(i_mem_rvalid), .i_mem_r(i_mem_r), .o_mem_rready(o_mem_rready),
    .o_refill(w_refill)
  );

endmodule

// ==== src.f ====
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_tlb.sv
rtl/lsu_l1d.sv
rtl/lsu_replay_q.sv
rtl/lsu_refill.sv
rtl/lsu_pipe.sv
rtl/lsu_top.sv
dv/lsu_checker.sv
dv/lsu_tb.sv
